//--- Makefile
# Verilator build and run of the calculator testbench

VERILATOR ?= verilator
TOP       ?= calculator_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# a failing check ends in $fatal, so the simulator exits non-zero
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- compile.f
source/calc_pkg.sv
source/board_pkg.sv
source/calc_if.sv
source/button_debouncer.sv
source/serial_divider.sv
source/arithmetic_unit.sv
source/calc_control.sv
source/calculator_top.sv
dv/calculator_props.sv
dv/calculator_tb.sv

//--- dv/calc_vectors_input.txt
// columns in hex: operand a, operand b, 11-bit operation word, expected result, expected error
// op bits: 400 add, 200 sub, 100 mul, 080 div, 040 and, 020 or, 010 xor, 008 shl, 004 shr, 002 max, 001 min
1234 4321 400 00005555 0
ffff ffff 400 0001fffe 0
0005 0007 200 fffffffe 0
9000 1000 200 00008000 0
ffff ffff 100 fffe0001 0
1234 0010 100 00012340 0
0064 0007 080 0002000e 0
ffff 0010 080 000f0fff 0
0005 0009 080 00050000 0
1234 0000 080 00000000 1
f0f0 3c3c 040 00003030 0
f0f0 0f0f 020 0000ffff 0
aaaa ffff 010 00005555 0
abcd 000c 008 0abcd000 0
ffff 001f 008 7fff8000 0
8000 0003 004 00001000 0
1234 0014 004 00000123 0
7fff 8000 002 00008000 0
7fff 8000 001 00007fff 0
0011 0022 000 00000000 1
0011 0022 600 00000000 1
0011 0022 7ff 00000000 1
ffff ffff 7ff ffffffff ff

//--- dv/calculator_props.sv
`timescale 1ns/1ps

module calculator_props (
    input logic                         clk_100mhz,
    input logic                         reset,
    input logic                         cmd_valid,
    input logic                         cmd_ready,
    input logic [calc_pkg::DATA_W-1:0]  cmd_operand_a,
    input logic [calc_pkg::DATA_W-1:0]  cmd_operand_b,
    input logic [calc_pkg::NUM_OPS-1:0] cmd_operation,
    input logic                         res_valid,
    input logic                         div_busy
);
    logic       in_flight;   // accepted, no result yet
    logic       div_accept;  // one-hot divide with a nonzero divisor taken
    logic [4:0] div_left;    // busy cycles still owed to that divide

    assign div_accept = cmd_valid && cmd_ready && $onehot(cmd_operation) &&
                        cmd_operation[calc_pkg::OP_DIV] && (cmd_operand_b != '0);

    always_ff @(posedge clk_100mhz) begin
        if (reset) begin
            in_flight <= 1'b0;
        end else if (cmd_valid && cmd_ready) begin
            in_flight <= 1'b1;
        end else if (res_valid) begin
            in_flight <= 1'b0;
        end
    end

    // one quotient bit per cycle after the divide is taken
    always_ff @(posedge clk_100mhz) begin
        if (reset) begin
            div_left <= '0;
        end else if (div_accept) begin
            div_left <= 5'(calc_pkg::DATA_W);
        end else if (div_left != '0) begin
            div_left <= div_left - 1'b1;
        end
    end

    cmd_held: assert property (@(posedge clk_100mhz) disable iff (reset)
        (cmd_valid && !cmd_ready) |=> (cmd_valid && $stable(cmd_operand_a) &&
            $stable(cmd_operand_b) && $stable(cmd_operation)))
        else $error("command changed before it was accepted");

    res_pulse: assert property (@(posedge clk_100mhz) disable iff (reset)
        res_valid |=> !res_valid)
        else $error("result valid held for two cycles");

    busy_stall: assert property (@(posedge clk_100mhz) disable iff (reset)
        (div_left != '0) |-> (div_busy && !cmd_ready))
        else $error("divider idle or ready high during a divide");

    res_after_cmd: assert property (@(posedge clk_100mhz) disable iff (reset)
        res_valid |-> in_flight)
        else $error("result valid without an accepted command");
endmodule

bind arithmetic_unit calculator_props i_props (
    .clk_100mhz    (clk_100mhz),
    .reset         (reset),
    .cmd_valid     (cmd.valid),
    .cmd_ready     (cmd.ready),
    .cmd_operand_a (cmd.operand_a),
    .cmd_operand_b (cmd.operand_b),
    .cmd_operation (cmd.operation),
    .res_valid     (res.valid),
    .div_busy      (div_busy)
);

//--- dv/calculator_tb.sv
`timescale 1ns/1ps

module calculator_tb;
    localparam int MAX_VECTORS   = 64;
    localparam int FIELDS        = 5;    // a, b, op, expected, error
    localparam int READY_TIMEOUT = 200;  // cycles, divide needs about 20
    localparam logic [10:0] ADD_WORD = 11'h400;
    localparam logic [10:0] MUL_WORD = 11'h100;

    logic                          clk_100mhz;
    logic                          reset;
    logic                          button_c;
    logic [calc_pkg::DATA_W-1:0]   input_data;
    logic [1:0]                    operand_selection;
    logic [calc_pkg::NUM_OPS-1:0]  operation;
    logic [calc_pkg::RESULT_W-1:0] result_out;
    logic                          result_ready_out;
    logic                          error_out;

    logic [31:0] vectors [0:MAX_VECTORS*FIELDS-1];
    integer      seed;
    int          idx;

    calculator_top #(
        .DEBOUNCE_CYCLES (4)
    ) i_dut (
        .clk_100mhz        (clk_100mhz),
        .reset             (reset),
        .button_c          (button_c),
        .input_data        (input_data),
        .operand_selection (operand_selection),
        .operation         (operation),
        .result_out        (result_out),
        .result_ready_out  (result_ready_out),
        .error_out         (error_out)
    );

    initial clk_100mhz = 1'b0;
    always #4 clk_100mhz = ~clk_100mhz;  // 8 ns period

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic wait_result_ready(input string name);
        int cycles;
        bit seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < READY_TIMEOUT) begin
            @(negedge clk_100mhz);
            seen = result_ready_out;
            cycles++;
        end
        if (!seen) begin
            $display("%s: the calculator gave no result within %0d cycles", name, READY_TIMEOUT);
            $display("Result: FAILED");
            $fatal(1, "timeout");
        end
    endtask

    // short bounces, each under the debounce length
    task automatic glitch_burst();
        int bursts;
        int len;
        bursts = 1 + int'($unsigned($random(seed)) % 2);
        repeat (bursts) begin
            len = 1 + int'($unsigned($random(seed)) % 3);
            @(posedge clk_100mhz);
            button_c <= 1'b1;
            repeat (len) @(posedge clk_100mhz);
            button_c <= 1'b0;
            repeat (4) @(posedge clk_100mhz);
        end
    endtask

    task automatic press_button(input logic [1:0] sel, input logic [15:0] data,
                                input logic [10:0] op);
        @(posedge clk_100mhz);
        operand_selection <= sel;
        input_data        <= data;
        operation         <= op;
        glitch_burst();
        button_c <= 1'b1;  // real press, 8 high then 8 low
        repeat (8) @(posedge clk_100mhz);
        button_c <= 1'b0;
        repeat (8) @(posedge clk_100mhz);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        seed              = 31;
        reset             = 1'b1;
        button_c          = 1'b0;
        input_data        = '0;
        operand_selection = '0;
        operation         = '0;
        $readmemh("dv/calc_vectors_input.txt", vectors);

        repeat (10) @(posedge clk_100mhz);
        reset <= 1'b0;
        @(negedge clk_100mhz);
        check_value("reset result", 32'd0, result_out);
        check_value("reset ready", 32'd0, 32'(result_ready_out));
        check_value("reset error", 32'd0, 32'(error_out));

        // an error column above 1 ends the table
        idx = 0;
        while (idx < MAX_VECTORS && vectors[idx*FIELDS+4] <= 32'd1) begin
            press_button(board_pkg::SEL_LOAD_A, vectors[idx*FIELDS][15:0],
                         vectors[idx*FIELDS+2][10:0]);
            press_button(board_pkg::SEL_LOAD_B, vectors[idx*FIELDS+1][15:0],
                         vectors[idx*FIELDS+2][10:0]);
            press_button(board_pkg::SEL_COMPUTE, vectors[idx*FIELDS+1][15:0],
                         vectors[idx*FIELDS+2][10:0]);
            wait_result_ready($sformatf("vector %0d", idx));
            check_value($sformatf("vector %0d result", idx), vectors[idx*FIELDS+3], result_out);
            check_value($sformatf("vector %0d error", idx), vectors[idx*FIELDS+4],
                        32'(error_out));
            idx++;
        end
        check_value("vectors read", 32'd1, 32'(idx > 0));

        // bounces alone must leave operand a at 3
        press_button(board_pkg::SEL_LOAD_A, 16'h0003, ADD_WORD);
        press_button(board_pkg::SEL_LOAD_B, 16'h0004, ADD_WORD);
        @(posedge clk_100mhz);
        operand_selection <= board_pkg::SEL_LOAD_A;
        input_data        <= 16'h0100;
        glitch_burst();
        repeat (8) @(posedge clk_100mhz);
        press_button(board_pkg::SEL_COMPUTE, 16'h0100, ADD_WORD);
        wait_result_ready("glitch filter");
        check_value("glitch filter result", 32'h0000_0007, result_out);

        press_button(board_pkg::SEL_COMPUTE, 16'h0100, MUL_WORD);  // ignored, result shown
        @(negedge clk_100mhz);
        check_value("second compute ready", 32'd1, 32'(result_ready_out));
        check_value("second compute result", 32'h0000_0007, result_out);

        press_button(board_pkg::SEL_LOAD_B, 16'h0005, MUL_WORD);
        @(negedge clk_100mhz);
        check_value("load clears ready", 32'd0, 32'(result_ready_out));
        press_button(board_pkg::SEL_COMPUTE, 16'h0005, MUL_WORD);
        wait_result_ready("multiply after load");
        check_value("multiply after load", 32'h0000_000F, result_out);

        press_button(board_pkg::SEL_CLEAR, 16'h0000, MUL_WORD);
        @(negedge clk_100mhz);
        check_value("clear result", 32'd0, result_out);
        check_value("clear ready", 32'd0, 32'(result_ready_out));

        $display("Result: PASSED");
        $finish;
    end
endmodule

//--- source/arithmetic_unit.sv
`timescale 1ns/1ps

module arithmetic_unit (
    input  logic     clk_100mhz,
    input  logic     reset,
    calc_cmd_if.unit cmd,
    calc_res_if.unit res
);
    logic                          accept;
    logic                          op_valid;     // exactly one switch up
    logic                          div_by_zero;
    logic                          div_start;
    logic [calc_pkg::RESULT_W-1:0] a_ext;
    logic [calc_pkg::RESULT_W-1:0] b_ext;
    logic [calc_pkg::RESULT_W-1:0] alu_value;
    logic                          res_valid_q;
    logic                          res_error_q;
    calc_pkg::result_word_u        res_value_q;
    calc_pkg::result_word_u        div_word;
    logic                          div_busy;
    logic                          div_done;
    logic [calc_pkg::DATA_W-1:0]   div_quotient;
    logic [calc_pkg::DATA_W-1:0]   div_remainder;

    assign accept      = cmd.valid && cmd.ready;
    assign op_valid    = $onehot(cmd.operation);
    assign div_by_zero = cmd.operation[calc_pkg::OP_DIV] && (cmd.operand_b == '0);
    assign div_start   = accept && op_valid && cmd.operation[calc_pkg::OP_DIV] && !div_by_zero;

    assign a_ext = calc_pkg::RESULT_W'(cmd.operand_a);  // unsigned, zero-extended
    assign b_ext = calc_pkg::RESULT_W'(cmd.operand_b);

    ////////////////////////////////////////////////////////////
    // single-cycle operations
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (1'b1)
            cmd.operation[calc_pkg::OP_ADD]: alu_value = a_ext + b_ext;
            cmd.operation[calc_pkg::OP_SUB]: alu_value = a_ext - b_ext;  // wraps mod 2^32
            cmd.operation[calc_pkg::OP_MUL]: alu_value = a_ext * b_ext;
            cmd.operation[calc_pkg::OP_AND]: alu_value = a_ext & b_ext;
            cmd.operation[calc_pkg::OP_OR]:  alu_value = a_ext | b_ext;
            cmd.operation[calc_pkg::OP_XOR]: alu_value = a_ext ^ b_ext;
            cmd.operation[calc_pkg::OP_SHL]: alu_value = a_ext << cmd.operand_b[3:0];
            cmd.operation[calc_pkg::OP_SHR]: alu_value = a_ext >> cmd.operand_b[3:0];
            cmd.operation[calc_pkg::OP_MAX]: alu_value = (a_ext > b_ext) ? a_ext : b_ext;
            cmd.operation[calc_pkg::OP_MIN]: alu_value = (a_ext < b_ext) ? a_ext : b_ext;
            default:                         alu_value = '0;  // divide goes to the divider
        endcase
    end

    always_ff @(posedge clk_100mhz) begin
        if (reset) begin
            res_valid_q <= 1'b0;
            res_error_q <= 1'b0;
        end else begin
            res_valid_q <= accept && !div_start;
            if (accept) res_error_q <= !op_valid || div_by_zero;
        end
    end

    always_ff @(posedge clk_100mhz) begin
        if (accept) res_value_q.word <= (op_valid && !div_by_zero) ? alu_value : '0;
    end

    // 16 cycles of restoring division
    serial_divider i_divider (
        .clk_100mhz (clk_100mhz),
        .reset      (reset),
        .start      (div_start),
        .dividend   (cmd.operand_a),
        .divisor    (cmd.operand_b),
        .busy       (div_busy),
        .done       (div_done),
        .quotient   (div_quotient),
        .remainder  (div_remainder)
    );

    always_comb begin
        div_word.div.quotient  = div_quotient;
        div_word.div.remainder = div_remainder;
    end

    // hold off while any result is still on its way out
    assign cmd.ready = !(div_busy || div_done || res_valid_q);

    assign res.valid = res_valid_q || div_done;
    assign res.value = div_done ? div_word : res_value_q;
    assign res.error = div_done ? 1'b0 : res_error_q;
endmodule

//--- source/board_pkg.sv
package board_pkg;

    // center button action, taken from the two selection switches
    localparam logic [1:0] SEL_LOAD_A  = 2'd0;
    localparam logic [1:0] SEL_LOAD_B  = 2'd1;
    localparam logic [1:0] SEL_COMPUTE = 2'd2;
    localparam logic [1:0] SEL_CLEAR   = 2'd3;

    // stable cycles before a button level is believed
    // 10 ms at the 100 MHz board clock
    localparam int DEBOUNCE_DEFAULT = 1_000_000;

endpackage

//--- source/button_debouncer.sv
`timescale 1ns/1ps

module button_debouncer #(
    parameter int DEBOUNCE_CYCLES = board_pkg::DEBOUNCE_DEFAULT
) (
    input  logic clk_100mhz,
    input  logic reset,
    input  logic button,
    output logic press
);
    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    logic             sync_meta;
    logic             sync_level;
    logic             stable_level;  // last accepted level
    logic [CNT_W-1:0] count;         // cycles the input has disagreed
    logic             flip;

    // two-flop synchronizer on the raw pin
    always_ff @(posedge clk_100mhz) begin
        if (reset) begin
            sync_meta  <= 1'b0;
            sync_level <= 1'b0;
        end else begin
            sync_meta  <= button;
            sync_level <= sync_meta;
        end
    end

    assign flip = (sync_level != stable_level) &&
                  (count == CNT_W'(DEBOUNCE_CYCLES - 1));

    always_ff @(posedge clk_100mhz) begin
        if (reset) begin
            stable_level <= 1'b0;
            count        <= '0;
            press        <= 1'b0;
        end else begin
            press <= flip && sync_level;  // rising edges only
            if (sync_level == stable_level) begin
                count <= '0;  // glitch over, start again
            end else if (flip) begin
                stable_level <= sync_level;
                count        <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end
endmodule

//--- source/calc_control.sv
`timescale 1ns/1ps

module calc_control (
    input  logic                          clk_100mhz,
    input  logic                          reset,
    input  logic                          press,
    input  logic [calc_pkg::DATA_W-1:0]   input_data,
    input  logic [1:0]                    operand_selection,
    input  logic [calc_pkg::NUM_OPS-1:0]  operation,
    calc_cmd_if.ctrl                      cmd,
    calc_res_if.ctrl                      res,
    output logic [calc_pkg::RESULT_W-1:0] result_out,
    output logic                          result_ready_out,
    output logic                          error_out
);
    logic [calc_pkg::DATA_W-1:0]  operand_a;
    logic [calc_pkg::DATA_W-1:0]  operand_b;
    calc_pkg::result_word_u       result_q;
    logic                         result_ready;
    logic                         error_q;
    logic                         cmd_valid;
    logic                         waiting;  // accepted, result not back yet
    logic                         compute_go;
    logic [calc_pkg::DATA_W-1:0]  cmd_a;
    logic [calc_pkg::DATA_W-1:0]  cmd_b;
    logic [calc_pkg::NUM_OPS-1:0] cmd_op;

    // a compute press counts only with nothing shown and nothing in flight
    assign compute_go = press && (operand_selection == board_pkg::SEL_COMPUTE) &&
                        !result_ready && !cmd_valid && !waiting;

    ////////////////////////////////////////////////////////////
    // operand and result registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_100mhz) begin
        if (reset) begin
            operand_a    <= '0;
            operand_b    <= '0;
            result_q     <= '0;
            result_ready <= 1'b0;
            error_q      <= 1'b0;
            cmd_valid    <= 1'b0;
            waiting      <= 1'b0;
        end else begin
            if (press) begin
                case (operand_selection)
                    board_pkg::SEL_LOAD_A: begin
                        operand_a    <= input_data;
                        result_ready <= 1'b0;
                    end
                    board_pkg::SEL_LOAD_B: begin
                        operand_b    <= input_data;
                        result_ready <= 1'b0;
                    end
                    board_pkg::SEL_CLEAR: begin
                        result_q     <= '0;
                        error_q      <= 1'b0;
                        result_ready <= 1'b0;
                    end
                    default: ;  // compute handled through compute_go
                endcase
            end
            if (compute_go) cmd_valid <= 1'b1;
            if (cmd_valid && cmd.ready) begin
                cmd_valid <= 1'b0;
                waiting   <= 1'b1;
            end
            if (res.valid) begin  // a result always wins
                result_q     <= res.value;
                error_q      <= res.error;
                result_ready <= 1'b1;
                waiting      <= 1'b0;
            end
        end
    end

    // command fields frozen at the press, held until the handshake
    always_ff @(posedge clk_100mhz) begin
        if (compute_go) begin
            cmd_a  <= operand_a;
            cmd_b  <= operand_b;
            cmd_op <= operation;
        end
    end

    assign cmd.valid        = cmd_valid;
    assign cmd.operand_a    = cmd_a;
    assign cmd.operand_b    = cmd_b;
    assign cmd.operation    = cmd_op;
    assign result_out       = result_q.word;
    assign result_ready_out = result_ready;
    assign error_out        = error_q;
endmodule

//--- source/calc_if.sv
`timescale 1ns/1ps

// command channel, control to arithmetic unit
interface calc_cmd_if;
    logic                         valid;
    logic                         ready;
    logic [calc_pkg::DATA_W-1:0]  operand_a;
    logic [calc_pkg::DATA_W-1:0]  operand_b;
    logic [calc_pkg::NUM_OPS-1:0] operation;  // raw switch word, should be one-hot

    modport ctrl (
        output valid,
        output operand_a,
        output operand_b,
        output operation,
        input  ready
    );

    modport unit (
        input  valid,
        input  operand_a,
        input  operand_b,
        input  operation,
        output ready
    );
endinterface

// result channel, no back-pressure
interface calc_res_if;
    logic                   valid;  // single-cycle pulse
    calc_pkg::result_word_u value;
    logic                   error;

    modport unit (output valid, output value, output error);
    modport ctrl (input valid, input value, input error);
endinterface

//--- source/calc_pkg.sv
package calc_pkg;

    localparam int DATA_W   = 16;  // operand width, one switch bank
    localparam int RESULT_W = 32;  // full product width
    localparam int NUM_OPS  = 11;  // one-hot operation switches

    // bit position of each operation switch, add on the top switch
    typedef enum int {
        OP_MIN = 0,
        OP_MAX = 1,
        OP_SHR = 2,
        OP_SHL = 3,
        OP_XOR = 4,
        OP_OR  = 5,
        OP_AND = 6,
        OP_DIV = 7,
        OP_MUL = 8,
        OP_SUB = 9,
        OP_ADD = 10
    } op_bit_e;

    // divide view, remainder in the high half
    typedef struct packed {
        logic [DATA_W-1:0] remainder;
        logic [DATA_W-1:0] quotient;
    } div_result_t;

    typedef union packed {
        logic [RESULT_W-1:0] word;  // plain value for every other op
        div_result_t         div;
    } result_word_u;

endpackage

//--- source/calculator_top.sv
`timescale 1ns/1ps

module calculator_top #(
    parameter int DEBOUNCE_CYCLES = board_pkg::DEBOUNCE_DEFAULT
) (
    input  logic                          clk_100mhz,
    input  logic                          reset,
    input  logic                          button_c,          // raw center button
    input  logic [calc_pkg::DATA_W-1:0]   input_data,
    input  logic [1:0]                    operand_selection,
    input  logic [calc_pkg::NUM_OPS-1:0]  operation,
    output logic [calc_pkg::RESULT_W-1:0] result_out,
    output logic                          result_ready_out,
    output logic                          error_out
);
    logic press;

    calc_cmd_if cmd_bus ();
    calc_res_if res_bus ();

    button_debouncer #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) i_debouncer (
        .clk_100mhz (clk_100mhz),
        .reset      (reset),
        .button     (button_c),
        .press      (press)
    );

    calc_control i_control (
        .clk_100mhz        (clk_100mhz),
        .reset             (reset),
        .press             (press),
        .input_data        (input_data),
        .operand_selection (operand_selection),
        .operation         (operation),
        .cmd               (cmd_bus.ctrl),
        .res               (res_bus.ctrl),
        .result_out        (result_out),
        .result_ready_out  (result_ready_out),
        .error_out         (error_out)
    );

    arithmetic_unit i_arith_unit (
        .clk_100mhz (clk_100mhz),
        .reset      (reset),
        .cmd        (cmd_bus.unit),
        .res        (res_bus.unit)
    );
endmodule

//--- source/serial_divider.sv
`timescale 1ns/1ps

module serial_divider (
    input  logic                        clk_100mhz,
    input  logic                        reset,
    input  logic                        start,
    input  logic [calc_pkg::DATA_W-1:0] dividend,
    input  logic [calc_pkg::DATA_W-1:0] divisor,
    output logic                        busy,
    output logic                        done,
    output logic [calc_pkg::DATA_W-1:0] quotient,
    output logic [calc_pkg::DATA_W-1:0] remainder
);
    localparam int STEP_W = $clog2(calc_pkg::DATA_W);

    // remainder and quotient shift together as one word
    calc_pkg::result_word_u      work;
    logic [calc_pkg::DATA_W-1:0] divisor_q;
    logic [STEP_W-1:0]           step;
    logic [calc_pkg::DATA_W:0]   partial;  // remainder shifted in, one spare bit
    logic [calc_pkg::DATA_W:0]   trial;

    assign partial = work.word[calc_pkg::RESULT_W-1:calc_pkg::DATA_W-1];
    assign trial   = partial - {1'b0, divisor_q};

    always_ff @(posedge clk_100mhz) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
            step <= '0;
        end else begin
            done <= 1'b0;
            if (start && !busy) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
                if (step == STEP_W'(calc_pkg::DATA_W - 1)) begin  // last quotient bit
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_100mhz) begin
        if (start && !busy) begin
            work.div.remainder <= '0;
            work.div.quotient  <= dividend;
            divisor_q          <= divisor;
        end else if (busy) begin
            if (!trial[calc_pkg::DATA_W]) begin  // no borrow, divisor fits
                work.div.remainder <= trial[calc_pkg::DATA_W-1:0];
                work.div.quotient  <= {work.div.quotient[calc_pkg::DATA_W-2:0], 1'b1};
            end else begin
                work.word <= work.word << 1;  // restore, quotient bit 0
            end
        end
    end

    assign quotient  = work.div.quotient;
    assign remainder = work.div.remainder;
endmodule
